//--- design/hsst_rst_cfg.svh
// Timing and width macros for the transceiver reset controller
//   watchdog counter widths, reset hold lengths,
//   status debounce length and retry counter width

`ifndef HSST_RST_CFG_SVH
`define HSST_RST_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Watchdog
//////////////////////////////////////////////////////////////////////

// First stage, MSB tick every 2**(W-1)+1 cycles, also the alarm length
`define HSST_WD_CNT1_W      5
// Second stage, MSB marks the timeout
`define HSST_WD_CNT2_W      5

//////////////////////////////////////////////////////////////////////
// Sequencer and synchronizers
//////////////////////////////////////////////////////////////////////

`define HSST_PLL_RST_CYC    8   // PLL reset hold, cycles
`define HSST_LANE_RST_CYC   6   // TX/RX lane reset hold, cycles

// Consecutive high samples before a status bit is trusted
`define HSST_DEB_CYC        4

`define HSST_RETRY_W        4   // Saturating retry counter

`endif

//--- design/hsst_rst_pkg.sv
// Shared types of the transceiver reset controller
//   seq_state_t  bring-up sequencer states
//   wd_st_t      watchdog status code

package hsst_rst_pkg;

    // Bring-up sequence, one state per step
    typedef enum logic [2:0]
    {
        S_IDLE       = 3'd0,  // PLL held in reset, waiting for req
        S_PLL_RST    = 3'd1,  // PLL reset hold
        S_PLL_WAIT   = 3'd2,  // Waiting for PLL lock
        S_LANE_RST   = 3'd3,  // TX and RX reset hold
        S_CDR_WAIT   = 3'd4,  // TX released, RX held until CDR lock
        S_ALIGN_WAIT = 3'd5,  // Waiting for word alignment
        S_READY      = 3'd6   // Link up, ack given
    } seq_state_t;

    // Watchdog status as seen by the host
    typedef enum logic [1:0]
    {
        WD_WAIT  = 2'd0,  // Cleared or link ok
        WD_COUNT = 2'd1,  // Timeout running
        WD_ALARM = 2'd2   // Timeout hit, reset pulse active
    } wd_st_t;

endpackage

//--- design/hsst_rst_sync.sv
// Status input conditioning for one asynchronous transceiver bit
//   two-flop synchronizer
//   rising-edge debounce over HSST_DEB_CYC samples
//   immediate release on a low sample

`include "hsst_rst_cfg.svh"

module hsst_rst_sync
(
    input  logic clk,
    input  logic rst_n,
    input  logic stat_in,   // Async from the PHY
    output logic stat_ok    // Synced and debounced
);

    localparam int DEB_W = $clog2(`HSST_DEB_CYC + 1);
    localparam logic [DEB_W-1:0] DEB_MAX = DEB_W'(`HSST_DEB_CYC);

    logic             meta_q;   // First flop, may go metastable
    logic             sync_q;   // Second flop, safe to use
    logic [DEB_W-1:0] deb_cnt;  // Run length of high samples

    //////////////////////////////////////////////////////////////////////
    // Synchronizer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            meta_q <= 1'b0;
            sync_q <= 1'b0;
        end
        else
        begin
            meta_q <= stat_in;
            sync_q <= meta_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Debounce
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            deb_cnt <= '0;
        else if (!sync_q)
            deb_cnt <= '0;                 // Any low sample restarts the run
        else if (deb_cnt != DEB_MAX)
            deb_cnt <= deb_cnt + 1'b1;     // Saturates at DEB_MAX
    end

    // Falls with the synced bit, no debounce on the way down
    assign stat_ok = sync_q && (deb_cnt == DEB_MAX);

endmodule

//--- design/hsst_rst_wtchdg.sv
// Bring-up watchdog
//   first-stage tick counter
//   second-stage timeout counter stepping on each tick
//   registered reset pulse and status from the timeout MSB
//   self-clear of the second stage after one tick of alarm

`include "hsst_rst_cfg.svh"

module hsst_rst_wtchdg
    import hsst_rst_pkg::*;
#(
    parameter int CNT1_W = `HSST_WD_CNT1_W,  // Tick = 2**(CNT1_W-1)+1 cycles
    parameter int CNT2_W = `HSST_WD_CNT2_W   // Timeout = 2**(CNT2_W-1) ticks
)
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   wd_clr,    // Sequencer idle
    input  logic   wd_ok,     // Link up
    output logic   wd_rst_n,  // Low for one tick on timeout
    output wd_st_t wd_st
);

    logic [CNT1_W-1:0] cnt1;
    logic [CNT2_W-1:0] cnt2;
    logic              wd_hold;   // Stop and clear both stages
    logic              tick;      // First stage wrap
    logic              alarm;     // Timeout reached
    logic              alarm_end; // Alarm has lasted one tick

    assign wd_hold   = wd_clr | wd_ok;
    assign tick      = cnt1[CNT1_W-1];
    assign alarm     = cnt2[CNT2_W-1];
    assign alarm_end = alarm & cnt2[0];   // MSB and LSB both set

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cnt1 <= '0;
        else if (wd_hold || tick)
            cnt1 <= '0;                   // Wrap right after MSB
        else
            cnt1 <= cnt1 + 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cnt2 <= '0;
        else if (wd_hold || alarm_end)
            cnt2 <= '0;                   // Restart after the pulse
        else if (tick)
            cnt2 <= cnt2 + 1'b1;
    end

    // Reset pulse follows the MSB one cycle later
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wd_rst_n <= 1'b1;
        else
            wd_rst_n <= ~alarm;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wd_st <= WD_WAIT;
        else if (wd_hold)
            wd_st <= WD_WAIT;
        else if (alarm)
            wd_st <= WD_ALARM;
        else
            wd_st <= WD_COUNT;
    end

endmodule

//--- design/hsst_rst_seq.sv
// Lane bring-up sequencer
//   FSM from PLL reset to link ready
//   shared hold counter for the two reset states
//   registered PHY resets and req/ack acknowledge
//   watchdog pulse detect and saturating retry counter

`include "hsst_rst_cfg.svh"

module hsst_rst_seq
    import hsst_rst_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     link_req,   // Host request, four-phase
    input  logic                     pll_ok,
    input  logic                     cdr_ok,
    input  logic                     align_ok,
    input  logic                     wd_rst_n,   // Watchdog restart pulse
    output logic                     pll_rst,
    output logic                     tx_rst,
    output logic                     rx_rst,
    output logic                     link_ack,
    output logic                     link_up,    // To watchdog wd_ok
    output logic                     wd_clr,     // To watchdog wd_clr
    output logic [`HSST_RETRY_W-1:0] retry_cnt
);

    localparam int HOLD_MAX = (`HSST_PLL_RST_CYC > `HSST_LANE_RST_CYC) ?
                              `HSST_PLL_RST_CYC : `HSST_LANE_RST_CYC;
    localparam int HOLD_W   = $clog2(HOLD_MAX + 1);

    // Last count of each hold, state leaves on this value
    localparam logic [HOLD_W-1:0] PLL_HOLD_LAST  = HOLD_W'(`HSST_PLL_RST_CYC - 1);
    localparam logic [HOLD_W-1:0] LANE_HOLD_LAST = HOLD_W'(`HSST_LANE_RST_CYC - 1);

    seq_state_t        state;
    seq_state_t        state_nxt;
    logic [HOLD_W-1:0] hold_cnt;
    logic              hold_clr;
    logic              wd_rst_q;     // Previous wd_rst_n
    logic              wd_fall;      // New watchdog pulse

    //////////////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        if (!link_req)
            state_nxt = S_IDLE;                  // Req low always wins
        else if (!wd_rst_n && state != S_IDLE)
            state_nxt = S_PLL_RST;               // Watchdog restart
        else
        begin
            unique case (state)
                S_IDLE:       state_nxt = S_PLL_RST;
                S_PLL_RST:
                    if (hold_cnt == PLL_HOLD_LAST)
                        state_nxt = S_PLL_WAIT;
                S_PLL_WAIT:
                    if (pll_ok)
                        state_nxt = S_LANE_RST;
                S_LANE_RST:
                    if (hold_cnt == LANE_HOLD_LAST)
                        state_nxt = S_CDR_WAIT;
                S_CDR_WAIT:
                    if (cdr_ok)
                        state_nxt = S_ALIGN_WAIT;
                S_ALIGN_WAIT:
                    if (align_ok)
                        state_nxt = S_READY;
                S_READY:
                begin
                    if (!pll_ok)
                        state_nxt = S_PLL_RST;   // Whole chain again
                    else if (!cdr_ok || !align_ok)
                        state_nxt = S_LANE_RST;  // PLL still fine
                end
                default:      state_nxt = S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    //////////////////////////////////////////////////////////////////////
    // Hold counter
    //////////////////////////////////////////////////////////////////////

    // Restart on every state change and for as long as the pulse lasts
    assign hold_clr = (state_nxt != state) || !wd_rst_n;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            hold_cnt <= '0;
        else if (hold_clr)
            hold_cnt <= '0;
        else if (state == S_PLL_RST || state == S_LANE_RST)
            hold_cnt <= hold_cnt + 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////

    // Decoded from next state so the PHY resets come straight from flops
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pll_rst  <= 1'b1;        // PLL in reset while idle
            tx_rst   <= 1'b1;
            rx_rst   <= 1'b1;
            link_ack <= 1'b0;
        end
        else
        begin
            pll_rst  <= (state_nxt == S_IDLE) || (state_nxt == S_PLL_RST);
            tx_rst   <= (state_nxt <= S_LANE_RST);   // Relies on encoding order
            rx_rst   <= (state_nxt <= S_CDR_WAIT);   // RX waits for CDR lock
            // One cycle after S_READY is entered, drops as it is left
            link_ack <= (state == S_READY) && (state_nxt == S_READY);
        end
    end

    assign link_up = (state == S_READY);
    assign wd_clr  = (state == S_IDLE);

    //////////////////////////////////////////////////////////////////////
    // Retry count
    //////////////////////////////////////////////////////////////////////

    assign wd_fall = wd_rst_q && !wd_rst_n;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wd_rst_q  <= 1'b1;
            retry_cnt <= '0;
        end
        else
        begin
            wd_rst_q <= wd_rst_n;
            if (wd_fall && state != S_IDLE && retry_cnt != '1)
                retry_cnt <= retry_cnt + 1'b1;       // Saturating
        end
    end

endmodule

//--- design/hsst_rst_top.sv
// Reset controller top for one QSGMII transceiver lane
//   status synchronizers for PLL lock, CDR lock and word align
//   bring-up sequencer
//   bring-up watchdog

`include "hsst_rst_cfg.svh"

module hsst_rst_top
    import hsst_rst_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     link_req,
    input  logic                     pll_lock,    // Async
    input  logic                     cdr_lock,    // Async
    input  logic                     word_align,  // Async
    output logic                     pll_rst,
    output logic                     tx_rst,
    output logic                     rx_rst,
    output logic                     link_ack,
    output wd_st_t                   wd_st,
    output logic [`HSST_RETRY_W-1:0] retry_cnt
);

    logic pll_ok;
    logic cdr_ok;
    logic align_ok;
    logic link_up;
    logic wd_clr;
    logic wd_rst_n;

    //////////////////////////////////////////////////////////////////////
    // Status conditioning
    //////////////////////////////////////////////////////////////////////

    hsst_rst_sync u_sync_pll
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .stat_in (pll_lock),
        .stat_ok (pll_ok)
    );

    hsst_rst_sync u_sync_cdr
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .stat_in (cdr_lock),
        .stat_ok (cdr_ok)
    );

    hsst_rst_sync u_sync_align
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .stat_in (word_align),
        .stat_ok (align_ok)
    );

    //////////////////////////////////////////////////////////////////////
    // Sequencer and watchdog
    //////////////////////////////////////////////////////////////////////

    hsst_rst_seq u_seq
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .link_req  (link_req),
        .pll_ok    (pll_ok),
        .cdr_ok    (cdr_ok),
        .align_ok  (align_ok),
        .wd_rst_n  (wd_rst_n),
        .pll_rst   (pll_rst),
        .tx_rst    (tx_rst),
        .rx_rst    (rx_rst),
        .link_ack  (link_ack),
        .link_up   (link_up),
        .wd_clr    (wd_clr),
        .retry_cnt (retry_cnt)
    );

    hsst_rst_wtchdg u_wd
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .wd_clr   (wd_clr),
        .wd_ok    (link_up),     // Ready link stops the timeout
        .wd_rst_n (wd_rst_n),
        .wd_st    (wd_st)
    );

endmodule

//--- dv/hsst_rst_props.sv
// Concurrent assertions for the transceiver reset controller
//   ack rises only on a pending req
//   PLL reset and ack never together
//   watchdog status stays on legal codes
//   bind into the sequencer and into the watchdog

module hsst_rst_props
    import hsst_rst_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   link_req,
    input logic   link_ack,
    input logic   pll_rst,
    input wd_st_t wd_st
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;   // Failed assertions so far

    // Ack is registered, so the req that allowed it is one sample back
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(link_ack) |-> $past(link_req))
    else
    begin
        fail_cnt++;
        $error("link_ack rose without link_req");
    end

    rst_ack_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(pll_rst && link_ack))
    else
    begin
        fail_cnt++;
        $error("pll_rst and link_ack high together");
    end

    wd_st_legal: assert property (@(posedge clk) disable iff (!rst_n)
        wd_st inside {WD_WAIT, WD_COUNT, WD_ALARM})
    else
    begin
        fail_cnt++;
        $error("wd_st holds an illegal code");
    end

endmodule

//////////////////////////////////////////////////////////////////////
// Bind points
//////////////////////////////////////////////////////////////////////

bind hsst_rst_seq hsst_rst_props u_props
(
    .clk      (clk),
    .rst_n    (rst_n),
    .link_req (link_req),
    .link_ack (link_ack),
    .pll_rst  (pll_rst),
    .wd_st    (hsst_rst_pkg::WD_WAIT)   // No watchdog status in the sequencer
);

bind hsst_rst_wtchdg hsst_rst_props u_props
(
    .clk      (clk),
    .rst_n    (rst_n),
    .link_req (1'b1),                   // Handshake lives in the sequencer
    .link_ack (1'b0),
    .pll_rst  (1'b0),
    .wd_st    (wd_st)
);

//--- dv/hsst_rst_tb.sv
// Testbench for the transceiver reset controller
//   clock, reset and a PHY lock model with LCG jitter and glitches
//   stimulus table applied row by row through req/ack cycles
//   reset order monitor, value checks and cycle timeout

`include "hsst_rst_cfg.svh"

module hsst_rst_tb
    import hsst_rst_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NEVER     = -1;                             // Input never rises
    localparam int RETRY_MAX = (1 << `HSST_RETRY_W) - 1;
    localparam int SYNC_LAT  = 2 + `HSST_DEB_CYC;              // Sync plus debounce
    localparam int WD_TICK   = (1 << (`HSST_WD_CNT1_W - 1)) + 1;
    localparam int WD_PERIOD = WD_TICK * ((1 << (`HSST_WD_CNT2_W - 1)) + 1);  // Timeout + alarm
    localparam int JIT_MAX   = 3;

    logic                     clk;
    logic                     rst_n;
    logic                     link_req;
    logic                     pll_lock;
    logic                     cdr_lock;
    logic                     word_align;
    logic                     pll_rst;
    logic                     tx_rst;
    logic                     rx_rst;
    logic                     link_ack;
    wd_st_t                   wd_st;
    logic [`HSST_RETRY_W-1:0] retry_cnt;

    // Stimulus table, one entry per row
    string row_name[$];
    int    row_pll[$];      // Lock delays in cycles, NEVER keeps the input low
    int    row_cdr[$];
    int    row_align[$];
    bit    row_glitch[$];   // Short pll_lock pulses before the real lock
    int    row_drop[$];     // Cycles after ack to drop cdr_lock, 0 for none
    bit    row_ready[$];    // Link is expected to come up
    int    row_trips[$];    // Watchdog timeouts to wait for

    // PHY model state
    int          pll_dly;
    int          cdr_dly;
    int          align_dly;
    bit          glitch_en;
    logic        drop_req;
    logic        drop_hold;    // CDR kept low until the lane is reset
    int          pll_cnt;
    int          cdr_cnt;
    int          align_cnt;
    int          glitch_left;
    int          glitch_gap;
    logic [31:0] glitch_seed;
    logic [31:0] jit_seed;

    int          pll_run;      // Consecutive cycles of pll_lock high
    logic        tx_rst_q;
    logic        rx_rst_q;
    int          cyc_cnt;
    int          cyc_limit;
    int          exp_retry;    // Retry count predicted from the alarms seen
    string       cur_name;

    hsst_rst_top dut0
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .link_req   (link_req),
        .pll_lock   (pll_lock),
        .cdr_lock   (cdr_lock),
        .word_align (word_align),
        .pll_rst    (pll_rst),
        .tx_rst     (tx_rst),
        .rx_rst     (rx_rst),
        .link_ack   (link_ack),
        .wd_st      (wd_st),
        .retry_cnt  (retry_cnt)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // 0 to 3 extra cycles on a finite delay
    function automatic int with_jitter(input int dly);
        if (dly == NEVER)
            return NEVER;
        jit_seed = lcg_next(jit_seed);
        return dly + int'(jit_seed[17:16]);
    endfunction

    task automatic report_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("error: test %s, %s expected %0d, actual %0d", cur_name, what, exp, act);
        $display("TESTBENCH FAILED");
    endtask

    task automatic report_plain(input string msg);
        $display("test %s: %s", cur_name, msg);
        $display("TESTBENCH FAILED");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else
        begin
            report_value(what, exp, act);
            $fatal(1, "value check");
        end
    endtask

    task automatic add_row(input string name, input int pll, input int cdr, input int align,
                           input bit glitch, input int drop, input bit ready, input int trips);
        row_name.push_back(name);
        row_pll.push_back(pll);
        row_cdr.push_back(cdr);
        row_align.push_back(align);
        row_glitch.push_back(glitch);
        row_drop.push_back(drop);
        row_ready.push_back(ready);
        row_trips.push_back(trips);
    endtask

    task automatic load_table();
        //       name            pll  cdr    align  glt drop rdy trips
        add_row("normal",        10,  12,    8,     0,  0,   1,  0);
        add_row("glitch",        40,  10,    6,     1,  0,   1,  0);
        add_row("wd_recover",    10,  NEVER, 6,     0,  0,   0,  2);
        add_row("lock_loss",     8,   10,    5,     0,  20,  1,  0);
        add_row("wd_saturate",   5,   8,     NEVER, 0,  0,   0,  15);
        add_row("back_to_back",  4,   4,     4,     0,  0,   1,  0);
        add_row("back_to_back2", 6,   3,     5,     0,  0,   1,  0);
    endtask

    // Worst-case bring-up per row plus two watchdog periods, and a margin
    function automatic int run_budget();
        int total;
        int one;
        total = 40;
        for (int r = 0; r < row_name.size(); r++)
        begin
            one = 1 + `HSST_PLL_RST_CYC + `HSST_LANE_RST_CYC + 3 * (SYNC_LAT + JIT_MAX) + 10;
            one += (row_pll[r] > 0) ? row_pll[r] : 0;
            one += (row_cdr[r] > 0) ? row_cdr[r] : 0;
            one += (row_align[r] > 0) ? row_align[r] : 0;
            if (row_drop[r] > 0)
                one = 2 * one + row_drop[r];    // Second bring-up after the loss
            total += one + (row_trips[r] + 2) * WD_PERIOD;
        end
        return total + 200;
    endfunction

    task automatic wait_ack(input logic level);
        do
            @(negedge clk);
        while (link_ack !== level);
    endtask

    // Link just came up, no retry and a quiet watchdog
    task automatic check_ready();
        check_value("retry_cnt at ack", exp_retry, retry_cnt);
        check_value("wd_st at ack", WD_WAIT, wd_st);
    endtask

    //////////////////////////////////////////////////////////////////////
    // PHY model
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (pll_rst)
        begin
            pll_cnt     <= 0;
            pll_lock    <= 1'b0;
            glitch_left <= 0;
            glitch_gap  <= 2;
        end
        else if (pll_dly != NEVER && pll_cnt >= pll_dly)
            pll_lock <= 1'b1;                       // Real lock, stays up
        else
        begin
            pll_cnt <= pll_cnt + 1;
            if (!glitch_en)
                pll_lock <= 1'b0;
            else if (glitch_left > 0)
            begin
                pll_lock    <= 1'b1;
                glitch_left <= glitch_left - 1;
            end
            else if (glitch_gap > 0)
            begin
                pll_lock   <= 1'b0;
                glitch_gap <= glitch_gap - 1;
            end
            else
            begin
                // New pulse of 1 to DEB_CYC-1 cycles, then a low gap
                glitch_seed <= lcg_next(glitch_seed);
                pll_lock    <= 1'b1;
                glitch_left <= int'(glitch_seed[17:16]) % (`HSST_DEB_CYC - 1);
                glitch_gap  <= 2 + int'(glitch_seed[19:18]);
            end
        end

        if (drop_req)
            drop_hold <= 1'b1;
        else if (tx_rst)
            drop_hold <= 1'b0;                      // Lane reset seen, relock allowed

        // CDR locks once TX is out of reset
        if (tx_rst || drop_hold || drop_req)
        begin
            cdr_cnt  <= 0;
            cdr_lock <= 1'b0;
        end
        else if (cdr_dly != NEVER && cdr_cnt >= cdr_dly)
            cdr_lock <= 1'b1;
        else
            cdr_cnt <= cdr_cnt + 1;

        // Alignment needs RX released
        if (rx_rst || !cdr_lock)
        begin
            align_cnt  <= 0;
            word_align <= 1'b0;
        end
        else if (align_dly != NEVER && align_cnt >= align_dly)
            word_align <= 1'b1;
        else
            align_cnt <= align_cnt + 1;
    end

    // Reset order monitor, lane resets fall only on a stable PLL lock
    always @(negedge clk)
    begin
        pll_run = pll_lock ? pll_run + 1 : 0;
        if (rst_n)
        begin
            if (tx_rst_q && !tx_rst)
            begin
                check_value("pll_rst at tx_rst release", 0, pll_rst);
                assert (pll_run >= SYNC_LAT + `HSST_LANE_RST_CYC)
                else
                begin
                    report_value("min stable pll_lock cycles at tx_rst release",
                                 SYNC_LAT + `HSST_LANE_RST_CYC, pll_run);
                    $fatal(1, "reset order");
                end
            end
            if (rx_rst_q && !rx_rst)
            begin
                check_value("pll_rst at rx_rst release", 0, pll_rst);
                check_value("cdr_lock at rx_rst release", 1, cdr_lock);
            end
        end
        tx_rst_q = tx_rst;
        rx_rst_q = rx_rst;
    end

    //////////////////////////////////////////////////////////////////////
    // One table row, one req/ack cycle
    //////////////////////////////////////////////////////////////////////

    task automatic run_row(input int r);
        int alarms;
        bit in_alarm;
        cur_name = row_name[r];
        alarms   = 0;
        in_alarm = 1'b0;
        check_value("link_ack before req", 0, link_ack);   // Spacing from last row
        @(posedge clk);
        pll_dly   <= with_jitter(row_pll[r]);
        cdr_dly   <= with_jitter(row_cdr[r]);
        align_dly <= with_jitter(row_align[r]);
        glitch_en <= row_glitch[r];
        link_req  <= 1'b1;

        if (row_ready[r])
        begin
            wait_ack(1'b1);
            check_ready();
            if (row_drop[r] > 0)
            begin
                repeat (row_drop[r]) @(posedge clk);
                drop_req <= 1'b1;
                @(posedge clk);
                drop_req <= 1'b0;
                wait_ack(1'b0);
                check_value("rx_rst after lock loss", 1, rx_rst);
                check_value("pll_rst after lock loss", 0, pll_rst);   // PLL stays locked
                wait_ack(1'b1);
                check_ready();
            end
        end
        else
        begin
            while (alarms < row_trips[r])
            begin
                @(negedge clk);
                check_value("link_ack without a ready link", 0, link_ack);
                if (wd_st == WD_ALARM && !in_alarm)
                begin
                    alarms++;
                    if (exp_retry < RETRY_MAX)
                        exp_retry++;               // Saturates at the top
                    repeat (2) @(negedge clk);
                    check_value("pll_rst during alarm", 1, pll_rst);
                    check_value("retry_cnt after alarm", exp_retry, retry_cnt);
                end
                in_alarm = (wd_st == WD_ALARM);
            end
        end

        @(posedge clk);
        link_req <= 1'b0;
        wait_ack(1'b0);
        repeat (3) @(negedge clk);
        check_value("pll_rst after req drop", 1, pll_rst);
        check_value("wd_st after req drop", WD_WAIT, wd_st);
        check_value("retry_cnt at row end", exp_retry, retry_cnt);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main flow and timeout
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        rst_n       = 1'b0;
        link_req    = 1'b0;
        pll_lock    = 1'b0;
        cdr_lock    = 1'b0;
        word_align  = 1'b0;
        drop_req    = 1'b0;
        drop_hold   = 1'b0;
        glitch_en   = 1'b0;
        pll_dly     = NEVER;
        cdr_dly     = NEVER;
        align_dly   = NEVER;
        pll_cnt     = 0;
        cdr_cnt     = 0;
        align_cnt   = 0;
        glitch_left = 0;
        glitch_gap  = 0;
        glitch_seed = 32'd82597;
        jit_seed    = 32'd82597;
        pll_run     = 0;
        tx_rst_q    = 1'b1;
        rx_rst_q    = 1'b1;
        cyc_cnt     = 0;
        exp_retry   = 0;
        cur_name    = "reset";
        load_table();
        cyc_limit = run_budget();

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("pll_rst after reset", 1, pll_rst);
        check_value("tx_rst after reset", 1, tx_rst);
        check_value("rx_rst after reset", 1, rx_rst);
        check_value("link_ack after reset", 0, link_ack);
        check_value("wd_rst_n after reset", 1, dut0.wd_rst_n);
        check_value("wd_st after reset", WD_WAIT, wd_st);
        check_value("retry_cnt after reset", 0, retry_cnt);

        for (int r = 0; r < row_name.size(); r++)
            run_row(r);

        cur_name = "end";
        if (dut0.u_seq.u_props.fail_cnt + dut0.u_wd.u_props.fail_cnt == 0)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            report_plain("bound property checks failed during the run");
            $fatal(1, "property checks");
        end
    end

    initial
    begin
        @(posedge clk);
        while (cyc_cnt < cyc_limit)
        begin
            @(posedge clk);
            cyc_cnt++;
        end
        report_plain($sformatf("timeout, run not finished after %0d cycles", cyc_limit));
        $fatal(1, "timeout");
    end

endmodule

//--- compile.f
+incdir+design
design/hsst_rst_pkg.sv
design/hsst_rst_sync.sv
design/hsst_rst_wtchdg.sv
design/hsst_rst_seq.sv
design/hsst_rst_top.sv
dv/hsst_rst_props.sv
dv/hsst_rst_tb.sv
